//--- Makefile
# Verilator build and run for the DDRAM hub testbench

TOP := pgm_ddram_hub_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- dv/pgm_ddram_hub_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pgm_ddram_hub_checker (
    input logic fixed_50m_clk,
    input logic reset,
    input logic ddram_rd,
    input logic ddram_we,
    input logic ioctl_download,
    input logic ioctl_wait
);

    // Read and write share one port, never both in a cycle
    rd_we_exclusive: assert property (
        @(posedge fixed_50m_clk) disable iff (reset)
        !(ddram_rd && ddram_we)
    ) else $error("ddram_rd and ddram_we high in the same cycle");

    // Loader owns the bus during a download
    no_rd_in_download: assert property (
        @(posedge fixed_50m_clk) disable iff (reset)
        ioctl_download |-> !ddram_rd
    ) else $error("read strobe issued while ioctl_download is high");

    // Host stall follows the pending write exactly
    wait_is_we: assert property (
        @(posedge fixed_50m_clk) disable iff (reset)
        ioctl_wait == ddram_we
    ) else $error("ioctl_wait differs from ddram_we");

endmodule

`default_nettype wire

//--- dv/pgm_ddram_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pgm_ddram_hub_tb;

    import pgm_mem_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_BUDGET = 3000;   // Cycles per test for the watchdog
    localparam int ACK_TIMEOUT = 200;

    logic        fixed_50m_clk;
    logic        reset;
    logic        ioctl_download, ioctl_wr, ioctl_wait;
    ioctl_addr_t ioctl_addr;
    cpu_word_t   ioctl_dout, cpu_data;
    logic [7:0]  ioctl_index;
    logic        cpu_req, cpu_ack, video_req, video_ack, sound_req, sound_ack;
    cpu_addr_t   cpu_addr;
    ddram_addr_t video_addr, sound_addr, ddram_addr;
    ddram_data_t video_data, sound_data, ddram_din, ddram_dout;
    ddram_be_t   ddram_be;
    logic        ddram_rd, ddram_we, ddram_busy, ddram_dout_ready;

    // DDRAM model state
    ddram_data_t mem [ddram_addr_t];         // Sparse line store with fill for unwritten lines
    cpu_word_t   shadow [cpu_addr_t];        // Words written by the loader test
    cpu_addr_t   loaded_q [$];
    ddram_addr_t rd_addr_q [$];
    ddram_addr_t wr_addr_q [$];
    ddram_data_t wr_data_q [$];
    ddram_be_t   wr_be_q [$];
    logic [31:0] seed = 32'habf2_8a5e;
    logic        busy_hold;
    int          rd_count, wr_count, ack_count, rd_wait, errors, checks;
    ddram_data_t rd_line;
    logic        cpu_ack_q, video_ack_q, sound_ack_q;

    pgm_ddram_hub #(.LOADER_ROM_INDEX(8'd0)) i_pgm_ddram_hub (.*);

    bind pgm_ddram_hub pgm_ddram_hub_checker i_pgm_ddram_hub_checker (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .ddram_rd      (ddram_rd),
        .ddram_we      (ddram_we),
        .ioctl_download(ioctl_download),
        .ioctl_wait    (ioctl_wait)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic ddram_data_t fill_line(input ddram_addr_t a);
        return {a, 3'b101, a, 3'b011};       // Every address bit shows up
    endfunction

    function automatic ddram_data_t line_at(input ddram_addr_t a);
        return mem.exists(a) ? mem[a] : fill_line(a);
    endfunction

    // Reference is the stored download word with the high byte first for the 68k
    function automatic cpu_word_t exp_cpu_word(input cpu_addr_t a);
        cpu_word_t w;
        w = shadow[a];
        return {w[7:0], w[15:8]};
    endfunction

    function automatic logic ack_of(input int which);
        case (which)
            0:       return cpu_ack;
            1:       return video_ack;
            default: return sound_ack;
        endcase
    endfunction

    initial begin
        fixed_50m_clk = 1'b0;
        forever #10 fixed_50m_clk = ~fixed_50m_clk;
    end

    // DDRAM model with random busy and 2 to 6 cycle read latency
    always @(posedge fixed_50m_clk) begin
        seed = xorshift32(seed);
        ddram_busy       <= busy_hold || (seed[1:0] == 2'd0);
        ddram_dout_ready <= 1'b0;
        if (ddram_we && !ddram_busy) begin
            rd_line = line_at(ddram_addr);
            for (int i = 0; i < 8; i++) begin
                if (ddram_be[i]) rd_line[8*i +: 8] = ddram_din[8*i +: 8];
            end
            mem[ddram_addr] = rd_line;
            wr_count++;
            wr_addr_q.push_back(ddram_addr);
            wr_data_q.push_back(ddram_din);
            wr_be_q.push_back(ddram_be);
        end
        if (ddram_rd && !ddram_busy) begin
            rd_count++;
            rd_addr_q.push_back(ddram_addr);
            rd_wait = 2 + int'(seed[12:8] % 5);
        end else if (rd_wait > 0) begin
            if (rd_wait == 1) begin
                ddram_dout_ready <= 1'b1;
                ddram_dout       <= line_at(rd_addr_q[$]);
            end
            rd_wait--;
        end
    end

    // Compare every ack rise against the reference
    always @(negedge fixed_50m_clk) begin
        if (!reset) begin
            if (cpu_ack && !cpu_ack_q) begin
                checks++;
                ack_count++;
                if (cpu_data !== exp_cpu_word(cpu_addr)) begin
                    errors++;
                    $display("CHECK FAILED cpu_data: got %h expected %h",
                             cpu_data, exp_cpu_word(cpu_addr));
                end
            end
            if (video_ack && !video_ack_q) begin
                checks++;
                ack_count++;
                if (video_data !== line_at(video_addr)) begin
                    errors++;
                    $display("CHECK FAILED video_data: got %h expected %h",
                             video_data, line_at(video_addr));
                end
            end
            if (sound_ack && !sound_ack_q) begin
                checks++;
                ack_count++;
                if (sound_data !== line_at(sound_addr)) begin
                    errors++;
                    $display("CHECK FAILED sound_data: got %h expected %h",
                             sound_data, line_at(sound_addr));
                end
            end
        end
        cpu_ack_q   = cpu_ack;
        video_ack_q = video_ack;
        sound_ack_q = sound_ack;
    end

    task automatic wait_ack(input int which, input logic level);
        int n;
        n = 0;
        while (ack_of(which) !== level && n < ACK_TIMEOUT) begin
            @(negedge fixed_50m_clk);
            n++;
        end
        if (ack_of(which) !== level) begin
            errors++;
            $display("ack of client %0d did not reach %0d in %0d cycles", which, level, n);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("test %s %s, %0d errors", name,
                 (errors == err_start) ? "ok" : "bad", errors - err_start);
    endtask

    // One download word and the write it leaves on the pins
    task automatic load_word(input ioctl_addr_t a, input cpu_word_t w);
        int n;
        @(posedge fixed_50m_clk);
        ioctl_addr <= a;
        ioctl_dout <= w;
        ioctl_wr   <= 1'b1;
        @(posedge fixed_50m_clk);
        ioctl_wr <= 1'b0;
        n = 0;
        while (wr_addr_q.size() == 0 && n < ACK_TIMEOUT) begin
            @(negedge fixed_50m_clk);
            n++;
        end
        if (wr_addr_q.size() == 0) begin
            errors++;
            $display("loader write never reached the DDRAM");
            return;
        end
        checks++;
        if (wr_addr_q[0] !== {5'b0, a[26:3]} || wr_data_q[0] !== {4{w}} ||
            wr_be_q[0] !== (8'h03 << (2 * a[2:1]))) begin
            errors++;
            $display("CHECK FAILED ddram write: addr %h data %h be %h for ioctl_addr %h word %h",
                     wr_addr_q[0], wr_data_q[0], wr_be_q[0], a, w);
        end
        void'(wr_addr_q.pop_front());
        void'(wr_data_q.pop_front());
        void'(wr_be_q.pop_front());
        shadow[a[23:1]] = w;
        loaded_q.push_back(a[23:1]);
        while (ioctl_wait) @(negedge fixed_50m_clk);
    endtask

    task automatic read_one(input int which);
        cpu_addr_t ca;
        seed = xorshift32(seed);
        ca   = loaded_q[seed[31:4] % loaded_q.size()];
        @(posedge fixed_50m_clk);
        case (which)
            0: begin
                cpu_addr <= ca;
                cpu_req  <= 1'b1;
            end
            1: begin
                video_addr <= {18'b0, seed[10:0]};
                video_req  <= 1'b1;
            end
            default: begin
                sound_addr <= {18'b0, seed[21:11]};
                sound_req  <= 1'b1;
            end
        endcase
        wait_ack(which, 1'b1);
        @(posedge fixed_50m_clk);
        cpu_req   <= 1'b0;
        video_req <= 1'b0;
        sound_req <= 1'b0;
        wait_ack(which, 1'b0);
    endtask

    initial begin
        int e0;
        int r0;
        int a0;
        reset = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_index = 8'd0;
        cpu_req = 1'b0;
        cpu_addr = '0;
        video_req = 1'b0;
        video_addr = '0;
        sound_req = 1'b0;
        sound_addr = '0;
        ddram_dout = '0;
        ddram_busy = 1'b0;
        ddram_dout_ready = 1'b0;
        busy_hold = 1'b0;
        repeat (10) @(posedge fixed_50m_clk);
        reset <= 1'b0;

        // Loader writes with the lane stepping each word
        e0 = errors;
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b1;
        @(negedge fixed_50m_clk);
        for (int i = 0; i < 16; i++) begin
            seed = xorshift32(seed);
            load_word({15'b0, seed[11:3], 2'(i), 1'b0}, seed[31:16]);
        end
        busy_hold <= 1'b1;                  // Keep the write pending
        @(posedge fixed_50m_clk);
        w0_start: begin
            r0 = wr_count;
            ioctl_addr <= 27'h000_0100;
            ioctl_dout <= 16'h5aa5;
            ioctl_wr   <= 1'b1;
            @(posedge fixed_50m_clk);
            ioctl_wr <= 1'b0;
            @(negedge fixed_50m_clk);
            if (!ioctl_wait) begin
                errors++;
                $display("ioctl_wait did not rise with a pending write");
            end
            @(posedge fixed_50m_clk);
            ioctl_addr <= 27'h000_0102;
            ioctl_dout <= 16'hdead;
            ioctl_wr   <= 1'b1;             // Dropped while waiting
            @(posedge fixed_50m_clk);
            ioctl_wr  <= 1'b0;
            busy_hold <= 1'b0;
            repeat (20) @(negedge fixed_50m_clk);
            checks++;
            if (wr_count - r0 != 1 || wr_data_q[0] !== {4{16'h5aa5}}) begin
                errors++;
                $display("CHECK FAILED write count: %h writes for one pulse", wr_count - r0);
            end
            shadow[23'h80] = 16'h5aa5;
            wr_addr_q.delete();
            wr_data_q.delete();
            wr_be_q.delete();
        end
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        end_test("loader", e0);

        // CPU reads of every loaded word
        e0 = errors;
        foreach (loaded_q[i]) begin
            @(posedge fixed_50m_clk);
            cpu_addr <= loaded_q[i];
            cpu_req  <= 1'b1;
            wait_ack(0, 1'b1);
            @(posedge fixed_50m_clk);
            cpu_req <= 1'b0;
            wait_ack(0, 1'b0);
        end
        end_test("cpu_read", e0);

        // All three raised together from idle
        e0 = errors;
        rd_addr_q.delete();
        @(posedge fixed_50m_clk);
        cpu_addr   <= loaded_q[0];
        video_addr <= 29'h0000_1234;
        sound_addr <= 29'h0000_0777;
        cpu_req    <= 1'b1;
        video_req  <= 1'b1;
        sound_req  <= 1'b1;
        wait_ack(0, 1'b1);
        wait_ack(1, 1'b1);
        wait_ack(2, 1'b1);
        checks++;
        if (rd_addr_q.size() != 3 || rd_addr_q[0] !== {8'b0, loaded_q[0][23:3]} ||
            rd_addr_q[1] !== 29'h0000_1234 || rd_addr_q[2] !== 29'h0000_0777) begin
            errors++;
            $display("CHECK FAILED read order: %0d reads, first %h", rd_addr_q.size(),
                     rd_addr_q.size() > 0 ? rd_addr_q[0] : 29'h0);
        end
        @(posedge fixed_50m_clk);
        cpu_req   <= 1'b0;
        video_req <= 1'b0;
        sound_req <= 1'b0;
        wait_ack(0, 1'b0);
        wait_ack(1, 1'b0);
        wait_ack(2, 1'b0);
        end_test("priority", e0);

        // Video level handshake
        e0 = errors;
        @(posedge fixed_50m_clk);
        video_addr <= 29'h0000_0042;
        video_req  <= 1'b1;
        wait_ack(1, 1'b1);
        repeat (8) begin
            @(negedge fixed_50m_clk);
            if (!video_ack) begin
                errors++;
                $display("video_ack fell while video_req was still high");
            end
        end
        @(posedge fixed_50m_clk);
        video_req <= 1'b0;
        wait_ack(1, 1'b0);
        end_test("video_read", e0);

        // Held sound request gives one read and a new edge one more
        e0 = errors;
        r0 = rd_count;
        @(posedge fixed_50m_clk);
        sound_addr <= 29'h0000_0321;
        sound_req  <= 1'b1;
        wait_ack(2, 1'b1);
        repeat (20) begin
            @(negedge fixed_50m_clk);
            if (!sound_ack) begin
                errors++;
                $display("sound_ack fell while sound_req was still high");
            end
        end
        checks++;
        if (rd_count - r0 != 1) begin
            errors++;
            $display("CHECK FAILED sound reads: %h for one held request", rd_count - r0);
        end
        @(posedge fixed_50m_clk);
        sound_req <= 1'b0;
        wait_ack(2, 1'b0);
        @(posedge fixed_50m_clk);
        sound_req <= 1'b1;
        wait_ack(2, 1'b1);
        @(posedge fixed_50m_clk);
        sound_req <= 1'b0;
        wait_ack(2, 1'b0);
        checks++;
        if (rd_count - r0 != 2) begin
            errors++;
            $display("CHECK FAILED sound reads: %h after two edges", rd_count - r0);
        end
        end_test("sound_read", e0);

        // One accepted read per ack under random busy
        e0 = errors;
        r0 = rd_count;
        a0 = ack_count;
        for (int i = 0; i < 24; i++) begin
            seed = xorshift32(seed);
            read_one(int'(seed[9:8] % 3));
        end
        checks++;
        if (rd_count - r0 != ack_count - a0) begin
            errors++;
            $display("CHECK FAILED read strobes: %h reads for %h acks",
                     rd_count - r0, ack_count - a0);
        end
        end_test("single_strobe", e0);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        repeat (NUM_TESTS * TEST_BUDGET + 10) @(posedge fixed_50m_clk);
        $display("watchdog expired after %0d cycles, run did not complete",
                 NUM_TESTS * TEST_BUDGET);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/ddram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ddram_arbiter (
    input  logic                    fixed_50m_clk,
    input  logic                    reset,
    input  logic                    ioctl_download,   // Loader owns the pins
    input  logic                    cpu_want,
    input  logic                    video_want,
    input  logic                    sound_want,
    input  pgm_mem_pkg::ddram_addr_t cpu_line_addr,
    input  pgm_mem_pkg::ddram_addr_t video_addr,
    input  pgm_mem_pkg::ddram_addr_t sound_addr,
    input  logic                    ddram_busy,
    input  logic                    ddram_dout_ready,
    input  pgm_mem_pkg::ddram_data_t ddram_dout,
    output pgm_mem_pkg::ddram_rsp_t  rsp,
    output logic                    rd,
    output pgm_mem_pkg::ddram_addr_t rd_addr
);

    import pgm_mem_pkg::*;

    grant_t state;
    logic   issued;     // Read already accepted for this grant
    logic   granted;

    assign granted = (state != grant_idle);

    // One strobe per grant, held back while the DDRAM is busy
    assign rd = !ioctl_download && granted && !issued && !ddram_busy;

    // Same bus goes to every reader
    assign rsp.data  = ddram_dout;
    assign rsp.done  = granted && ddram_dout_ready;
    assign rsp.grant = state;

    // Owner's address on the read path
    always_comb begin
        case (state)
            grant_cpu:   rd_addr = cpu_line_addr;
            grant_video: rd_addr = video_addr;
            grant_sound: rd_addr = sound_addr;
            default:     rd_addr = cpu_line_addr;   // Idle, not strobed
        endcase
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state  <= grant_idle;
            issued <= 1'b0;
        end else if (ioctl_download) begin
            // Download pre-empts everything, grant is dropped
            state  <= grant_idle;
            issued <= 1'b0;
        end else begin
            case (state)
                grant_idle: begin
                    issued <= 1'b0;
                    // Fixed priority
                    if (cpu_want) begin
                        state <= grant_cpu;
                    end else if (video_want) begin
                        state <= grant_video;
                    end else if (sound_want) begin
                        state <= grant_sound;
                    end
                end
                default: begin
                    if (!issued && !ddram_busy) begin
                        issued <= 1'b1;             // Strobe accepted this cycle
                    end
                    if (ddram_dout_ready) begin
                        state  <= grant_idle;       // Done pulse ends the grant
                        issued <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/ddram_loader.sv
`timescale 1ns/1ps
`default_nettype none

module ddram_loader #(
    parameter logic [7:0] LOADER_ROM_INDEX = 8'd0   // Download slot that goes to DDRAM
) (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,         // One-cycle pulse per word
    input  pgm_mem_pkg::ioctl_addr_t ioctl_addr,
    input  pgm_mem_pkg::cpu_word_t   ioctl_dout,
    input  logic [7:0]               ioctl_index,
    input  logic                     ddram_busy,
    output pgm_mem_pkg::loader_wr_t  wr
);

    import pgm_mem_pkg::*;

    logic        pending;
    logic        accept;
    ddram_addr_t addr_q;
    ddram_data_t data_q;
    ddram_be_t   be_q;
    ddram_be_t   be_next;

    // Pulses while a write is still pending are dropped, host waits on ioctl_wait
    assign accept = ioctl_download && ioctl_wr && (ioctl_index == LOADER_ROM_INDEX) && !pending;

    // Byte pair of the 16-bit word inside the line
    always_comb begin
        case (ioctl_addr[2:1])
            2'd0:    be_next = 8'h03;
            2'd1:    be_next = 8'h0C;
            2'd2:    be_next = 8'h30;
            default: be_next = 8'hC0;
        endcase
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            pending <= 1'b0;    // End of download also drops a stuck write
        end else if (accept) begin
            pending <= 1'b1;
        end else if (pending && !ddram_busy) begin
            pending <= 1'b0;    // Taken by the DDRAM this cycle
        end
    end

    // Write payload, stable while waiting on busy
    always_ff @(posedge fixed_50m_clk) begin
        if (accept) begin
            addr_q <= {5'b0, ioctl_addr[26:3]};
            data_q <= {4{ioctl_dout}};    // Same word on every lane, be picks one
            be_q   <= be_next;
        end
    end

    assign wr.pending = pending;
    assign wr.addr    = addr_q;
    assign wr.data    = data_q;
    assign wr.be      = be_q;

endmodule

`default_nettype wire

//--- logic/line_fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module line_fetch_port (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    input  logic                     video_req,     // Level request
    input  pgm_mem_pkg::ddram_rsp_t  rsp,
    output logic                     want,
    output logic                     video_ack,
    output pgm_mem_pkg::ddram_data_t video_data
);

    import pgm_mem_pkg::*;

    logic line_done;

    assign line_done = rsp.done && (rsp.grant == grant_video);

    assign want = video_req && !video_ack;

    // Hold the line, dout is gone after the pulse
    always_ff @(posedge fixed_50m_clk) begin
        if (line_done) begin
            video_data <= rsp.data;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            video_ack <= 1'b0;
        end else if (line_done) begin
            video_ack <= 1'b1;
        end else if (!video_req) begin
            video_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/pgm_ddram_hub.sv
`timescale 1ns/1ps
`default_nettype none

module pgm_ddram_hub #(
    parameter logic [7:0] LOADER_ROM_INDEX = 8'd0
) (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,

    // Host download
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,
    input  pgm_mem_pkg::ioctl_addr_t ioctl_addr,
    input  pgm_mem_pkg::cpu_word_t   ioctl_dout,
    input  logic [7:0]               ioctl_index,
    output logic                     ioctl_wait,

    // Read clients
    input  logic                     cpu_req,
    input  pgm_mem_pkg::cpu_addr_t   cpu_addr,
    output logic                     cpu_ack,
    output pgm_mem_pkg::cpu_word_t   cpu_data,
    input  logic                     video_req,
    input  pgm_mem_pkg::ddram_addr_t video_addr,
    output logic                     video_ack,
    output pgm_mem_pkg::ddram_data_t video_data,
    input  logic                     sound_req,
    input  pgm_mem_pkg::ddram_addr_t sound_addr,
    output logic                     sound_ack,
    output pgm_mem_pkg::ddram_data_t sound_data,

    // DDRAM port
    output logic                     ddram_rd,
    output logic                     ddram_we,
    output pgm_mem_pkg::ddram_addr_t ddram_addr,
    output pgm_mem_pkg::ddram_data_t ddram_din,
    output pgm_mem_pkg::ddram_be_t   ddram_be,
    input  pgm_mem_pkg::ddram_data_t ddram_dout,
    input  logic                     ddram_busy,
    input  logic                     ddram_dout_ready
);

    import pgm_mem_pkg::*;

    ddram_rsp_t  rsp;            // Broadcast to all readers
    loader_wr_t  wr;
    ddram_addr_t rd_addr;
    ddram_addr_t cpu_line_addr;
    logic        cpu_want;
    logic        video_want;
    logic        sound_want;

    // 64-bit line holding the CPU word
    assign cpu_line_addr = {8'b0, cpu_addr[23:3]};

    ddram_arbiter i_ddram_arbiter (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .ioctl_download   (ioctl_download),
        .cpu_want         (cpu_want),
        .video_want       (video_want),
        .sound_want       (sound_want),
        .cpu_line_addr    (cpu_line_addr),
        .video_addr       (video_addr),
        .sound_addr       (sound_addr),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready),
        .ddram_dout       (ddram_dout),
        .rsp              (rsp),
        .rd               (ddram_rd),
        .rd_addr          (rd_addr)
    );

    rom_read_port i_rom_read_port (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .cpu_req       (cpu_req),
        .cpu_addr      (cpu_addr),
        .rsp           (rsp),
        .want          (cpu_want),
        .cpu_ack       (cpu_ack),
        .cpu_data      (cpu_data)
    );

    line_fetch_port i_line_fetch_port (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .video_req     (video_req),
        .rsp           (rsp),
        .want          (video_want),
        .video_ack     (video_ack),
        .video_data    (video_data)
    );

    sample_fetch_port i_sample_fetch_port (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .sound_req     (sound_req),
        .rsp           (rsp),
        .want          (sound_want),
        .sound_ack     (sound_ack),
        .sound_data    (sound_data)
    );

    ddram_loader #(
        .LOADER_ROM_INDEX (LOADER_ROM_INDEX)
    ) i_ddram_loader (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ddram_busy     (ddram_busy),
        .wr             (wr)
    );

    // Loader wins the address while downloading, reads are held off then
    assign ddram_we   = wr.pending;
    assign ddram_addr = ioctl_download ? wr.addr : rd_addr;
    assign ddram_din  = wr.data;
    assign ddram_be   = wr.pending ? wr.be : READ_BE;
    assign ioctl_wait = wr.pending;     // Host stalls until the write lands

endmodule

`default_nettype wire

//--- logic/pgm_mem_pkg.sv
`default_nettype none

package pgm_mem_pkg;

    // DDRAM side, one 64-bit line per word address
    typedef logic [28:0] ddram_addr_t;
    typedef logic [63:0] ddram_data_t;
    typedef logic [7:0]  ddram_be_t;      // One enable per byte of the line

    // Client side
    typedef logic [23:1] cpu_addr_t;      // 68k byte address, A0 never driven
    typedef logic [15:0] cpu_word_t;      // CPU bus word, also the download word
    typedef logic [26:0] ioctl_addr_t;    // Download byte address from the host

    // Current owner of the read path
    typedef enum logic [1:0] {
        grant_idle  = 2'd0,
        grant_cpu   = 2'd1,
        grant_video = 2'd2,
        grant_sound = 2'd3
    } grant_t;

    // Arbiter to all readers; each port compares grant with its own slot
    typedef struct packed {
        ddram_data_t data;                // Raw ddram_dout, valid with done only
        logic        done;                // Ready pulse seen during a grant
        grant_t      grant;
    } ddram_rsp_t;

    // Latched loader write, held until the DDRAM takes it
    typedef struct packed {
        logic        pending;
        ddram_addr_t addr;
        ddram_data_t data;
        ddram_be_t   be;
    } loader_wr_t;

    localparam ddram_be_t READ_BE = 8'hFF; // Reads always fetch the full line

endpackage

`default_nettype wire

//--- logic/rom_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module rom_read_port (
    input  logic                    fixed_50m_clk,
    input  logic                    reset,
    input  logic                    cpu_req,      // Level, held until ack
    input  pgm_mem_pkg::cpu_addr_t  cpu_addr,
    input  pgm_mem_pkg::ddram_rsp_t rsp,
    output logic                    want,
    output logic                    cpu_ack,
    output pgm_mem_pkg::cpu_word_t  cpu_data
);

    import pgm_mem_pkg::*;

    ddram_data_t line_buf;   // Last line fetched for the CPU
    cpu_word_t   lane_word;
    logic        line_done;

    assign line_done = rsp.done && (rsp.grant == grant_cpu);

    // Ask only until the ack is up
    assign want = cpu_req && !cpu_ack;

    // Line is only valid on the ready pulse
    always_ff @(posedge fixed_50m_clk) begin
        if (line_done) begin
            line_buf <= rsp.data;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            cpu_ack <= 1'b0;
        end else if (line_done) begin
            cpu_ack <= 1'b1;
        end else if (!cpu_req) begin
            cpu_ack <= 1'b0;    // Level ack drops after the request
        end
    end

    // A2:A1 pick the 16-bit lane, lane 0 in the low bits
    always_comb begin
        case (cpu_addr[2:1])
            2'd0:    lane_word = line_buf[15:0];
            2'd1:    lane_word = line_buf[31:16];
            2'd2:    lane_word = line_buf[47:32];
            default: lane_word = line_buf[63:48];
        endcase
    end

    // DDRAM is little endian, 68k wants the high byte first
    assign cpu_data = {lane_word[7:0], lane_word[15:8]};

endmodule

`default_nettype wire

//--- logic/sample_fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fetch_port (
    input  logic                     fixed_50m_clk,
    input  logic                     reset,
    input  logic                     sound_req,     // Edge starts a read
    input  pgm_mem_pkg::ddram_rsp_t  rsp,
    output logic                     want,
    output logic                     sound_ack,
    output pgm_mem_pkg::ddram_data_t sound_data
);

    import pgm_mem_pkg::*;

    logic req_last;      // Request level of the previous cycle
    logic req_rise;
    logic read_pending;  // Edge seen, read not yet completed
    logic sample_done;

    assign req_rise    = sound_req && !req_last;
    assign sample_done = rsp.done && (rsp.grant == grant_sound);

    // Held request gives one read only
    assign want = req_rise || read_pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            req_last     <= 1'b0;
            read_pending <= 1'b0;
            sound_ack    <= 1'b0;
        end else begin
            req_last <= sound_req;
            if (sample_done) begin
                read_pending <= 1'b0;
            end else if (req_rise) begin
                read_pending <= 1'b1;
            end
            // Ack set by data, cleared only once the request is gone
            if (sample_done) begin
                sound_ack <= 1'b1;
            end else if (!sound_req) begin
                sound_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (sample_done) begin
            sound_data <= rsp.data;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/pgm_mem_pkg.sv
logic/ddram_arbiter.sv
logic/rom_read_port.sv
logic/line_fetch_port.sv
logic/sample_fetch_port.sv
logic/ddram_loader.sv
logic/pgm_ddram_hub.sv
dv/pgm_ddram_hub_checker.sv
dv/pgm_ddram_hub_tb.sv
